/* source/sat_pkg.sv */
// Sizes and clause encoding for the binned SAT solver.
// Imported by every RTL module and by the testbench reference model.

package sat_pkg;

	////////////////////
	// Bin geometry.
	////////////////////

	localparam int NUM_BINS          = 4;
	localparam int WIDTH_BIN_ID      = 2;
	localparam int NUM_VARS_A_BIN    = 8;
	localparam int NUM_CLAUSES_A_BIN = 8;

	////////////////////
	// Clause encoding.
	////////////////////

	// Two bits per variable, bit 2k is the positive literal.
	localparam int WIDTH_CLAUSE = 2 * NUM_VARS_A_BIN;
	localparam int LIT_POS      = 0;
	localparam int LIT_NEG      = 1;

	////////////////////
	// Count and index widths.
	////////////////////

	// Counts run 0 to 8 inclusive.
	localparam int WIDTH_NV   = 4;
	localparam int WIDTH_NC   = 4;
	localparam int WIDTH_SLOT = 3;

	// All clause slots of one bin side by side.
	localparam int WIDTH_BIN_CLAUSES = NUM_CLAUSES_A_BIN * WIDTH_CLAUSE;

endpackage

/* source/clause_store.sv */
// Clause memory and per-bin sizes, loaded by the host before a run.
// One read returns a whole bin, registered, one cycle after rd_bin_i.

module clause_store import sat_pkg::*; (
	input  logic                         clk,
	input  logic                         rst_i,
	input  logic                         cfg_clause_we_i,
	input  logic                         cfg_size_we_i,
	input  logic [WIDTH_BIN_ID-1:0]      cfg_bin_i,
	input  logic [WIDTH_SLOT-1:0]        cfg_slot_i,
	input  logic [WIDTH_CLAUSE-1:0]      cfg_clause_i,
	input  logic [WIDTH_NV-1:0]          cfg_nv_i,
	input  logic [WIDTH_NC-1:0]          cfg_nc_i,
	input  logic [WIDTH_BIN_ID-1:0]      rd_bin_i,
	output logic [WIDTH_BIN_CLAUSES-1:0] bin_clauses_o,
	output logic [WIDTH_NV-1:0]          bin_nv_o,
	output logic [WIDTH_NC-1:0]          bin_nc_o
);

	logic [WIDTH_CLAUSE-1:0] clause_mem [NUM_BINS][NUM_CLAUSES_A_BIN];
	logic [WIDTH_NV-1:0]     nv_q [NUM_BINS];
	logic [WIDTH_NC-1:0]     nc_q [NUM_BINS];

	always_ff @(posedge clk) begin
		if (cfg_clause_we_i) begin
			clause_mem[cfg_bin_i][cfg_slot_i] <= cfg_clause_i;
		end
	end

	// Empty bins after reset.
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int b = 0; b < NUM_BINS; b++) begin
				nv_q[b] <= '0;
				nc_q[b] <= '0;
			end
		end else if (cfg_size_we_i) begin
			nv_q[cfg_bin_i] <= cfg_nv_i;
			nc_q[cfg_bin_i] <= cfg_nc_i;
		end
	end

	// Registered read of the selected bin.
	always_ff @(posedge clk) begin
		for (int s = 0; s < NUM_CLAUSES_A_BIN; s++) begin
			bin_clauses_o[s*WIDTH_CLAUSE +: WIDTH_CLAUSE] <= clause_mem[rd_bin_i][s];
		end
		bin_nv_o <= nv_q[rd_bin_i];
		bin_nc_o <= nc_q[rd_bin_i];
	end

endmodule

/* source/clause_eval.sv */
// Checks every used clause slot of a bin against one assignment.
// Purely combinational, sits inside the engine.

module clause_eval import sat_pkg::*; (
	input  logic [WIDTH_BIN_CLAUSES-1:0] clauses_i,
	input  logic [WIDTH_NC-1:0]          nc_i,
	input  logic [NUM_VARS_A_BIN-1:0]    assign_i,
	output logic                         all_sat_o
);

	logic [NUM_CLAUSES_A_BIN-1:0] slot_ok;

	for (genvar s = 0; s < NUM_CLAUSES_A_BIN; s++) begin : g_slot
		logic [WIDTH_CLAUSE-1:0]   clause;
		logic [NUM_VARS_A_BIN-1:0] pos_lit;
		logic [NUM_VARS_A_BIN-1:0] neg_lit;
		logic                      unused_slot;
		logic                      hit;

		assign clause = clauses_i[s*WIDTH_CLAUSE +: WIDTH_CLAUSE];

		for (genvar k = 0; k < NUM_VARS_A_BIN; k++) begin : g_var
			assign pos_lit[k] = clause[2*k + LIT_POS];
			assign neg_lit[k] = clause[2*k + LIT_NEG];
		end

		// An empty clause never gets a hit.
		assign hit         = |((pos_lit & assign_i) | (neg_lit & ~assign_i));
		assign unused_slot = (nc_i <= WIDTH_NC'(s));
		assign slot_ok[s]  = unused_slot | hit;
	end

	assign all_sat_o = &slot_ok;

endmodule

/* source/sat_engine.sv */
// Exhaustive solver for one bin, trying assignments in counting order.
// Pulse start_core_i with the bin on the inputs; results come with done_core_o.
// Latency is one cycle per candidate tried, plus one.

module sat_engine import sat_pkg::*; (
	input  logic                         clk,
	input  logic                         rst_i,
	input  logic                         start_core_i,
	input  logic [WIDTH_BIN_CLAUSES-1:0] clauses_i,
	input  logic [WIDTH_NV-1:0]          nv_i,
	input  logic [WIDTH_NC-1:0]          nc_i,
	output logic                         done_core_o,
	output logic                         local_sat_o,
	output logic [NUM_VARS_A_BIN-1:0]    local_assign_o
);

	logic                         busy;
	logic [NUM_VARS_A_BIN-1:0]    cand;
	logic [WIDTH_BIN_CLAUSES-1:0] clauses_q;
	logic [WIDTH_NV-1:0]          nv_q;
	logic [WIDTH_NC-1:0]          nc_q;
	logic [NUM_VARS_A_BIN-1:0]    var_mask;
	logic                         cand_sat;
	logic                         last_cand;
	logic                         accept;

	assign accept = start_core_i & ~busy;

	////////////////////
	// Bin capture.
	////////////////////

	always_ff @(posedge clk) begin
		if (accept) begin
			clauses_q <= clauses_i;
			nv_q      <= nv_i;
			nc_q      <= nc_i;
		end
	end

	// Ones on the low nv variables.
	for (genvar k = 0; k < NUM_VARS_A_BIN; k++) begin : g_mask
		assign var_mask[k] = (WIDTH_NV'(k) < nv_q);
	end

	assign last_cand = (cand == var_mask);

	clause_eval clause_eval (
		.clauses_i (clauses_q),
		.nc_i      (nc_q),
		.assign_i  (cand),
		.all_sat_o (cand_sat)
	);

	////////////////////
	// Search.
	////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy        <= 1'b0;
			cand        <= '0;
			done_core_o <= 1'b0;
		end else begin
			done_core_o <= 1'b0;
			if (!busy) begin
				if (start_core_i) begin
					busy <= 1'b1;
					cand <= '0;
				end
			end else if (cand_sat || last_cand) begin
				busy        <= 1'b0;
				done_core_o <= 1'b1;
			end else begin
				cand <= cand + 1'b1;
			end
		end
	end

	// Result payload, valid with done_core_o.
	always_ff @(posedge clk) begin
		if (busy && (cand_sat || last_cand)) begin
			local_sat_o    <= cand_sat;
			local_assign_o <= cand_sat ? cand : '0;
		end
	end

endmodule

/* source/assign_store.sv */
// Per-bin verdicts and assignments from the last run.
// Written by the manager, read combinationally by the host.

module assign_store import sat_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      res_we_i,
	input  logic [WIDTH_BIN_ID-1:0]   res_bin_i,
	input  logic                      res_sat_i,
	input  logic [NUM_VARS_A_BIN-1:0] res_assign_i,
	input  logic                      clear_i,
	input  logic [WIDTH_BIN_ID-1:0]   host_bin_i,
	output logic                      host_sat_o,
	output logic [NUM_VARS_A_BIN-1:0] host_assign_o
);

	logic [NUM_BINS-1:0]       sat_q;
	logic [NUM_VARS_A_BIN-1:0] assign_q [NUM_BINS];

	// Skipped bins read back as not satisfied.
	always_ff @(posedge clk) begin
		if (rst_i || clear_i) begin
			sat_q <= '0;
		end else if (res_we_i) begin
			sat_q[res_bin_i] <= res_sat_i;
		end
	end

	always_ff @(posedge clk) begin
		if (clear_i) begin
			for (int b = 0; b < NUM_BINS; b++) begin
				assign_q[b] <= '0;
			end
		end else if (res_we_i) begin
			assign_q[res_bin_i] <= res_assign_i;
		end
	end

	assign host_sat_o    = sat_q[host_bin_i];
	assign host_assign_o = assign_q[host_bin_i];

endmodule

/* source/bin_manager.sv */
// Run control: walks bins 0 to num_bins-1 through the engine and
// records each verdict. Stops at the first UNSAT bin.

module bin_manager import sat_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      start_i,
	input  logic [WIDTH_BIN_ID:0]     num_bins_i,
	output logic                      done_o,
	output logic                      global_sat_o,
	output logic                      global_unsat_o,
	output logic [WIDTH_BIN_ID-1:0]   rd_bin_o,
	output logic                      start_core_o,
	input  logic                      done_core_i,
	input  logic                      local_sat_i,
	input  logic [NUM_VARS_A_BIN-1:0] local_assign_i,
	output logic                      res_we_o,
	output logic [WIDTH_BIN_ID-1:0]   res_bin_o,
	output logic                      res_sat_o,
	output logic [NUM_VARS_A_BIN-1:0] res_assign_o,
	output logic                      clear_o
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ,
		ST_LAUNCH,
		ST_WAIT,
		ST_RECORD,
		ST_FINISH
	} state_t;

	state_t                    state;
	logic [WIDTH_BIN_ID-1:0]   cur_bin;
	logic [WIDTH_BIN_ID-1:0]   last_bin;
	logic                      rec_sat;
	logic [NUM_VARS_A_BIN-1:0] rec_assign;
	logic                      accept;

	assign accept = start_i && (state == ST_IDLE);

	////////////////////
	// FSM.
	////////////////////

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state          <= ST_IDLE;
			cur_bin        <= '0;
			last_bin       <= '0;
			global_sat_o   <= 1'b0;
			global_unsat_o <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start_i) begin
						state          <= ST_READ;
						cur_bin        <= '0;
						last_bin       <= WIDTH_BIN_ID'(num_bins_i - 1'b1);
						global_sat_o   <= 1'b0;
						global_unsat_o <= 1'b0;
					end
				end
				ST_READ: begin
					state <= ST_LAUNCH;
				end
				ST_LAUNCH: begin
					state <= ST_WAIT;
				end
				ST_WAIT: begin
					if (done_core_i) begin
						state <= ST_RECORD;
					end
				end
				ST_RECORD: begin
					// Flags go up together with done_o.
					if (!rec_sat) begin
						state          <= ST_FINISH;
						global_unsat_o <= 1'b1;
					end else if (cur_bin == last_bin) begin
						state        <= ST_FINISH;
						global_sat_o <= 1'b1;
					end else begin
						state   <= ST_READ;
						cur_bin <= cur_bin + 1'b1;
					end
				end
				ST_FINISH: begin
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Engine result, held for the record cycle.
	always_ff @(posedge clk) begin
		if (state == ST_WAIT && done_core_i) begin
			rec_sat    <= local_sat_i;
			rec_assign <= local_assign_i;
		end
	end

	////////////////////
	// Outputs.
	////////////////////

	assign rd_bin_o     = cur_bin;
	assign start_core_o = (state == ST_LAUNCH);
	assign res_we_o     = (state == ST_RECORD);
	assign res_bin_o    = cur_bin;
	assign res_sat_o    = rec_sat;
	assign res_assign_o = rec_assign;
	assign clear_o      = accept;
	assign done_o       = (state == ST_FINISH);

endmodule

/* source/sat_bin.sv */
// Top of the binned SAT solver: clause store, bin manager, engine and
// result memory. Load the clauses and sizes, pulse start_i, wait for done_o.

module sat_bin import sat_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      start_i,
	input  logic [WIDTH_BIN_ID:0]     num_bins_i,
	input  logic                      cfg_clause_we_i,
	input  logic                      cfg_size_we_i,
	input  logic [WIDTH_BIN_ID-1:0]   cfg_bin_i,
	input  logic [WIDTH_SLOT-1:0]     cfg_slot_i,
	input  logic [WIDTH_CLAUSE-1:0]   cfg_clause_i,
	input  logic [WIDTH_NV-1:0]       cfg_nv_i,
	input  logic [WIDTH_NC-1:0]       cfg_nc_i,
	input  logic [WIDTH_BIN_ID-1:0]   res_bin_i,
	output logic                      done_o,
	output logic                      global_sat_o,
	output logic                      global_unsat_o,
	output logic                      res_sat_o,
	output logic [NUM_VARS_A_BIN-1:0] res_assign_o
);

	logic [WIDTH_BIN_ID-1:0]      rd_bin;
	logic [WIDTH_BIN_CLAUSES-1:0] bin_clauses;
	logic [WIDTH_NV-1:0]          bin_nv;
	logic [WIDTH_NC-1:0]          bin_nc;
	logic                         start_core;
	logic                         done_core;
	logic                         local_sat;
	logic [NUM_VARS_A_BIN-1:0]    local_assign;
	logic                         res_we;
	logic [WIDTH_BIN_ID-1:0]      res_bin;
	logic                         res_sat;
	logic [NUM_VARS_A_BIN-1:0]    res_assign;
	logic                         res_clear;

	clause_store clause_store (
		.clk             (clk),
		.rst_i           (rst_i),
		.cfg_clause_we_i (cfg_clause_we_i),
		.cfg_size_we_i   (cfg_size_we_i),
		.cfg_bin_i       (cfg_bin_i),
		.cfg_slot_i      (cfg_slot_i),
		.cfg_clause_i    (cfg_clause_i),
		.cfg_nv_i        (cfg_nv_i),
		.cfg_nc_i        (cfg_nc_i),
		.rd_bin_i        (rd_bin),
		.bin_clauses_o   (bin_clauses),
		.bin_nv_o        (bin_nv),
		.bin_nc_o        (bin_nc)
	);

	bin_manager bin_manager (
		.clk            (clk),
		.rst_i          (rst_i),
		.start_i        (start_i),
		.num_bins_i     (num_bins_i),
		.done_o         (done_o),
		.global_sat_o   (global_sat_o),
		.global_unsat_o (global_unsat_o),
		.rd_bin_o       (rd_bin),
		.start_core_o   (start_core),
		.done_core_i    (done_core),
		.local_sat_i    (local_sat),
		.local_assign_i (local_assign),
		.res_we_o       (res_we),
		.res_bin_o      (res_bin),
		.res_sat_o      (res_sat),
		.res_assign_o   (res_assign),
		.clear_o        (res_clear)
	);

	sat_engine sat_engine (
		.clk            (clk),
		.rst_i          (rst_i),
		.start_core_i   (start_core),
		.clauses_i      (bin_clauses),
		.nv_i           (bin_nv),
		.nc_i           (bin_nc),
		.done_core_o    (done_core),
		.local_sat_o    (local_sat),
		.local_assign_o (local_assign)
	);

	assign_store assign_store (
		.clk           (clk),
		.rst_i         (rst_i),
		.res_we_i      (res_we),
		.res_bin_i     (res_bin),
		.res_sat_i     (res_sat),
		.res_assign_i  (res_assign),
		.clear_i       (res_clear),
		.host_bin_i    (res_bin_i),
		.host_sat_o    (res_sat_o),
		.host_assign_o (res_assign_o)
	);

endmodule

/* tests/sat_ref.svh */
// Reference solver and random clause maker for the binned SAT testbench.
// Included inside the testbench module, after the sat_pkg import.

// One literal of variable k, negated or positive.
function automatic logic [WIDTH_CLAUSE-1:0] lit(input int k, input logic negated);
	logic [WIDTH_CLAUSE-1:0] c;
	c = '0;
	c[2*k + int'(negated)] = 1'b1;
	return c;
endfunction

// Lowest satisfying assignment in counting order, returned as {sat, assign}.
function automatic logic [NUM_VARS_A_BIN:0] solve_bin(
	input logic [WIDTH_BIN_CLAUSES-1:0] cl,
	input int                           nv,
	input int                           nc
);
	logic [NUM_VARS_A_BIN-1:0] a;
	logic                      found;
	logic                      all_ok;
	logic                      hit;
	int                        cand;
	a = '0;
	found = 1'b0;
	cand = 0;
	while (!found && cand < (1 << nv)) begin
		a = NUM_VARS_A_BIN'(cand);
		all_ok = 1'b1;
		// A slot with no literals never gets a hit.
		for (int s = 0; s < nc; s++) begin
			hit = 1'b0;
			for (int k = 0; k < NUM_VARS_A_BIN; k++) begin
				hit = hit | (cl[s*WIDTH_CLAUSE + 2*k] & a[k]);
				hit = hit | (cl[s*WIDTH_CLAUSE + 2*k + 1] & ~a[k]);
			end
			all_ok = all_ok & hit;
		end
		found = all_ok;
		cand++;
	end
	return found ? {1'b1, a} : '0;
endfunction

// One to three random literals over the low nv variables.
function automatic logic [WIDTH_CLAUSE-1:0] random_clause(input int nv);
	logic [WIDTH_CLAUSE-1:0] c;
	int                      n;
	c = '0;
	n = 1 + int'($urandom % 3);
	for (int i = 0; i < n && nv > 0; i++) begin
		c = c | lit(int'($urandom % nv), 1'($urandom % 2));
	end
	return c;
endfunction

/* tests/tb_sat_bin.sv */
// Testbench for the binned SAT solver. Loads hand-written and random
// formulas, runs them and checks flags and per-bin results against a reference.

module tb_sat_bin import sat_pkg::*; ();

	localparam int CLK_HALF     = 20;
	localparam int DONE_TIMEOUT = 2000;

	logic                         clk;
	logic                         rst_i;
	logic                         start_i;
	logic [WIDTH_BIN_ID:0]        num_bins_i;
	logic                         cfg_clause_we_i;
	logic                         cfg_size_we_i;
	logic [WIDTH_BIN_ID-1:0]      cfg_bin_i;
	logic [WIDTH_SLOT-1:0]        cfg_slot_i;
	logic [WIDTH_CLAUSE-1:0]      cfg_clause_i;
	logic [WIDTH_NV-1:0]          cfg_nv_i;
	logic [WIDTH_NC-1:0]          cfg_nc_i;
	logic [WIDTH_BIN_ID-1:0]      res_bin_i;
	logic                         done_o;
	logic                         global_sat_o;
	logic                         global_unsat_o;
	logic                         res_sat_o;
	logic [NUM_VARS_A_BIN-1:0]    res_assign_o;
	int                           val_errs = 0;
	int                           timeouts = 0;
	int                           runs = 0;
	int                           done_cnt = 0;
	logic [WIDTH_BIN_CLAUSES-1:0] clauses_m [NUM_BINS];
	int                           nv_m [NUM_BINS];
	int                           nc_m [NUM_BINS];

	`include "sat_ref.svh"

	sat_bin sat_bin_i (.*);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// Done pulses over the whole simulation.
	always @(negedge clk) begin
		if (done_o === 1'b1) begin
			done_cnt++;
		end
	end

	////////////////////
	// Host tasks.
	////////////////////

	task automatic write_clause(input int b, input int s, input logic [WIDTH_CLAUSE-1:0] c);
		cfg_clause_we_i = 1'b1;
		cfg_bin_i = WIDTH_BIN_ID'(b);
		cfg_slot_i = WIDTH_SLOT'(s);
		cfg_clause_i = c;
		@(negedge clk);
		cfg_clause_we_i = 1'b0;
		clauses_m[b][s*WIDTH_CLAUSE +: WIDTH_CLAUSE] = c;
	endtask

	task automatic write_size(input int b, input int nv, input int nc);
		cfg_size_we_i = 1'b1;
		cfg_bin_i = WIDTH_BIN_ID'(b);
		cfg_nv_i = WIDTH_NV'(nv);
		cfg_nc_i = WIDTH_NC'(nc);
		@(negedge clk);
		cfg_size_we_i = 1'b0;
		nv_m[b] = nv;
		nc_m[b] = nc;
	endtask

	// One run over nb bins. With stray set, start_i pulses again mid-run.
	task automatic run_bins(input int nb, input logic stray);
		logic                      exp_sat [NUM_BINS];
		logic [NUM_VARS_A_BIN-1:0] exp_assign [NUM_BINS];
		logic [NUM_VARS_A_BIN:0]   ref_res;
		logic                      all_sat;
		int                        n;
		all_sat = 1'b1;
		for (int b = 0; b < NUM_BINS; b++) begin
			exp_sat[b] = 1'b0;
			exp_assign[b] = '0;
			if (b < nb && all_sat) begin
				ref_res = solve_bin(clauses_m[b], nv_m[b], nc_m[b]);
				exp_sat[b] = ref_res[NUM_VARS_A_BIN];
				exp_assign[b] = ref_res[NUM_VARS_A_BIN-1:0];
				all_sat = ref_res[NUM_VARS_A_BIN];
			end
		end
		runs++;
		fork
			begin
				start_i = 1'b1;
				num_bins_i = (WIDTH_BIN_ID + 1)'(nb);
				@(negedge clk);
				start_i = 1'b0;
				if (stray) begin
					repeat (2) @(negedge clk);
					start_i = 1'b1;
					num_bins_i = (WIDTH_BIN_ID + 1)'(1);
					@(negedge clk);
					start_i = 1'b0;
				end
			end
			begin
				n = 0;
				do begin
					@(negedge clk);
					n++;
				end while (done_o !== 1'b1 && n < DONE_TIMEOUT);
			end
		join
		if (done_o !== 1'b1) begin
			$display("Timed out waiting for done_o after %0d cycles", n);
			timeouts++;
		end else begin
			if (global_sat_o !== all_sat) begin
				$display("FAIL global_sat_o got %h expected %h", global_sat_o, all_sat);
				val_errs++;
			end
			if (global_unsat_o !== !all_sat) begin
				$display("FAIL global_unsat_o got %h expected %h", global_unsat_o, !all_sat);
				val_errs++;
			end
			// Read back every bin, skipped ones too.
			for (int b = 0; b < NUM_BINS; b++) begin
				res_bin_i = WIDTH_BIN_ID'(b);
				@(negedge clk);
				if (res_sat_o !== exp_sat[b]) begin
					$display("FAIL res_sat_o bin %0d got %h expected %h", b, res_sat_o, exp_sat[b]);
					val_errs++;
				end
				if (exp_sat[b] && res_assign_o !== exp_assign[b]) begin
					$display("FAIL res_assign_o bin %0d got %h expected %h",
						b, res_assign_o, exp_assign[b]);
					val_errs++;
				end
			end
		end
	endtask

	////////////////////
	// Stimulus.
	////////////////////

	initial begin
		int nv;
		void'($urandom(32'h0913ab6c));
		rst_i = 1'b1;
		start_i = 1'b0;
		num_bins_i = '0;
		cfg_clause_we_i = 1'b0;
		cfg_size_we_i = 1'b0;
		cfg_bin_i = '0;
		cfg_slot_i = '0;
		cfg_clause_i = '0;
		cfg_nv_i = '0;
		cfg_nc_i = '0;
		res_bin_i = '0;
		for (int b = 0; b < NUM_BINS; b++) begin
			clauses_m[b] = '0;
			nv_m[b] = 0;
			nc_m[b] = 0;
		end
		repeat (2) @(negedge clk);
		rst_i = 1'b0;

		// Idle outputs, then empty bins.
		if (done_o !== 1'b0 || global_sat_o !== 1'b0 || global_unsat_o !== 1'b0) begin
			$display("FAIL done_o global_sat_o global_unsat_o got %h %h %h expected 0 0 0",
				done_o, global_sat_o, global_unsat_o);
			val_errs++;
		end
		run_bins(4, 1'b0);

		// Satisfiable hand-written bins.
		write_size(0, 3, 3);
		write_clause(0, 0, lit(0, 1'b0) | lit(1, 1'b0));
		write_clause(0, 1, lit(0, 1'b1) | lit(2, 1'b0));
		write_clause(0, 2, lit(1, 1'b0));
		write_size(1, 4, 2);
		write_clause(1, 0, lit(3, 1'b0));
		write_clause(1, 1, lit(3, 1'b1) | lit(2, 1'b0));
		write_size(2, 8, 1);
		write_clause(2, 0, lit(7, 1'b0));
		write_size(3, 2, 2);
		write_clause(3, 0, lit(0, 1'b0));
		write_clause(3, 1, lit(1, 1'b0));
		run_bins(4, 1'b0);

		// x0 and not x0 in bin 1, bins 2 and 3 skipped.
		write_size(1, 1, 2);
		write_clause(1, 0, lit(0, 1'b0));
		write_clause(1, 1, lit(0, 1'b1));
		run_bins(4, 1'b0);

		// Empty used slot, then conflicting slots beyond nc.
		write_size(0, 2, 2);
		write_clause(0, 1, '0);
		run_bins(1, 1'b0);
		write_size(0, 2, 1);
		write_clause(0, 0, lit(0, 1'b0));
		write_clause(0, 1, lit(0, 1'b1));
		run_bins(1, 1'b0);

		for (int r = 0; r < 40; r++) begin
			for (int b = 0; b < NUM_BINS; b++) begin
				nv = 1 + int'($urandom % NUM_VARS_A_BIN);
				write_size(b, nv, int'($urandom % (NUM_CLAUSES_A_BIN + 1)));
				for (int s = 0; s < NUM_CLAUSES_A_BIN; s++) begin
					write_clause(b, s, random_clause(nv));
				end
			end
			run_bins(1 + int'($urandom % NUM_BINS), 1'b0);
		end

		// Same formula twice, the second with a start pulse while busy.
		run_bins(4, 1'b0);
		run_bins(4, 1'b1);
		repeat (10) @(negedge clk);
		if (done_cnt != runs) begin
			$display("FAIL done_o pulse count got %h expected %h", done_cnt, runs);
			val_errs++;
		end

		$display("Errors: %0d value mismatches, %0d timeouts", val_errs, timeouts);
		if (val_errs == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+tests
source/sat_pkg.sv
source/clause_store.sv
source/clause_eval.sv
source/sat_engine.sv
source/assign_store.sv
source/bin_manager.sv
source/sat_bin.sv
tests/tb_sat_bin.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_sat_bin -Mdir obj_dir -f list.f
./obj_dir/Vtb_sat_bin | tee sim.log
if grep -qF '*** PASSED ***' sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
